/* testbench/testdata.mem */
// I <hex word>: program word, one per address starting at 0
// S <hex address> <hex data>: expected store, in program order
I 00500093  // 00 addi x1, x0, 5
I ffd00113  // 04 addi x2, x0, -3
I 002081b3  // 08 add  x3, x1, x2
I 00302023  // 0c sw   x3, 0(x0)
I 40208233  // 10 sub  x4, x1, x2
I 001262b3  // 14 or   x5, x4, x1
I 00402223  // 18 sw   x4, 4(x0)
I 00502423  // 1c sw   x5, 8(x0)
I 00117333  // 20 and  x6, x2, x1
I 001123b3  // 24 slt  x7, x2, x1
I 0020a433  // 28 slt  x8, x1, x2
I 00602623  // 2c sw   x6, 12(x0)
I 00702823  // 30 sw   x7, 16(x0)
I 00802a23  // 34 sw   x8, 20(x0)
I 0f017493  // 38 andi x9, x2, 0xf0
I f004e513  // 3c ori  x10, x9, -256
I ff152593  // 40 slti x11, x10, -15
I 00a02c23  // 44 sw   x10, 24(x0)
I 00b02e23  // 48 sw   x11, 28(x0)
I 08002603  // 4c lw   x12, 128(x0)
I 001606b3  // 50 add  x13, x12, x1
I 02d02023  // 54 sw   x13, 32(x0)
I 00208463  // 58 beq  x1, x2, +8
I 02102223  // 5c sw   x1, 36(x0)
I 00318663  // 60 beq  x3, x3, +12
I 02402423  // 64 sw   x4, 40(x0)
I 02402623  // 68 sw   x4, 44(x0)
I 00c0076f  // 6c jal  x14, +12
I 02502823  // 70 sw   x5, 48(x0)
I 02502a23  // 74 sw   x5, 52(x0)
I 02e02c23  // 78 sw   x14, 56(x0)
I 0000006f  // 7c jal  x0, 0
S 00000000 00000002  // 5 + -3
S 00000004 00000008  // 5 - -3
S 00000008 0000000d  // 8 | 5
S 0000000c 00000005  // -3 & 5
S 00000010 00000001  // -3 < 5
S 00000014 00000000  // 5 < -3
S 00000018 fffffff0  // 0xf0 | -256
S 0000001c 00000001  // -16 < -15
S 00000020 3c5a0085  // word at 0x80 plus 5
S 00000024 00000005  // beq not taken
S 00000038 00000070  // jal link

/* sources.f */
source/rvPkg.sv
source/alu.sv
source/regFile.sv
source/controlDecoder.sv
source/hazardUnit.sv
source/pipelineDatapath.sv
source/rvPipelineCore.sv
testbench/storeChecker.sv
testbench/tbTop.sv

/* Makefile */
# Verilator build and run of the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= tbTop
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tbTop.sv */
// ================================================
// testbench for the pipelined core, with memory
// models and a program from the test data file
// ================================================
`timescale 1ns/1ps

module tbTop import rvPkg::*; ();

  localparam int    ImemWords = 64;
  localparam int    DmemWords = 64;
  localparam int    MaxStores = 32;
  localparam string DataFile  = "testbench/testdata.mem";

  logic clk;
  logic arstN;
  wordT instr;
  wordT readData;
  wordT pc;
  wordT dataAdr;
  wordT writeData;
  logic memWrite;

  wordT instrMem [ImemWords];
  wordT dataMem  [DmemWords];
  wordT expAdr   [MaxStores];
  wordT expData  [MaxStores];
  int   numWords;
  int   numStores;
  int   loadErrors;  // file could not be read
  logic done;
  int   valueErrors;
  int   otherErrors;

  rvPipelineCore #(.resetPc(32'h0)) u_dut (
    .clk(clk), .arstN(arstN), .instr(instr), .readData(readData),
    .pc(pc), .memWrite(memWrite), .dataAdr(dataAdr), .writeData(writeData)
  );

  storeChecker #(.MaxStores(MaxStores)) uChecker (
    .clk(clk), .arstN(arstN), .memWrite(memWrite), .pc(pc),
    .dataAdr(dataAdr), .writeData(writeData),
    .expAdr(expAdr), .expData(expData),
    .numStores(numStores), .numWords(numWords),
    .done(done), .valueErrors(valueErrors), .otherErrors(otherErrors)
  );

  always #2 clk = ~clk;  // 4 ns period

  // data memory content before any store
  function automatic wordT dataFill(input int idx);
    return (idx * 4) ^ 32'h3c5a_0000;
  endfunction

  // I lines fill the program, S lines the expected stores
  task automatic loadTestData();
    int    fd;
    int    n;
    string line;
    wordT  a;
    wordT  b;
    fd = $fopen(DataFile, "r");
    if (fd == 0) begin
      $display("cannot open the test data file %s", DataFile);
      loadErrors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 3) continue;
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
      if (line[0] == "I" && n >= 1 && numWords < ImemWords) begin
        instrMem[numWords] = a;
        numWords++;
      end else if (line[0] == "S" && n == 2 && numStores < MaxStores) begin
        expAdr[numStores]  = a;
        expData[numStores] = b;
        numStores++;
      end
    end
    $fclose(fd);
  endtask

  // ================================================
  // stimulus and reset
  // ================================================
  initial begin
    clk        = 1'b0;
    arstN      = 1'b0;
    instr      = '0;
    readData   = '0;
    numWords   = 0;
    numStores  = 0;
    loadErrors = 0;
    for (int i = 0; i < ImemWords; i++) instrMem[i] = '0;  // zero word is a bubble
    for (int i = 0; i < DmemWords; i++) dataMem[i] = dataFill(i);
    for (int i = 0; i < MaxStores; i++) begin
      expAdr[i]  = '0;
      expData[i] = '0;
    end
    loadTestData();
    repeat (4) @(negedge clk);
    arstN = 1'b1;
  end

  // memories answer on the falling edge
  always @(negedge clk) begin
    instr    <= instrMem[pc[7:2]];
    readData <= dataMem[dataAdr[7:2]];
  end

  always @(posedge clk) begin
    if (arstN && memWrite) dataMem[dataAdr[7:2]] <= writeData;
  end

  // ================================================
  // end of run
  // ================================================
  initial begin
    wait (done);
    $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors + loadErrors);
    if (valueErrors == 0 && otherErrors == 0 && loadErrors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* testbench/storeChecker.sv */
// ================================================
// store port monitor with expected store sequence
// and cycle limit
// ================================================
`timescale 1ns/1ps

module storeChecker import rvPkg::*; #(
  parameter int MaxStores   = 32,
  parameter int DrainCycles = 20   // quiet cycles after the last store
) (
  input  logic clk,
  input  logic arstN,
  input  logic memWrite,
  input  wordT pc,
  input  wordT dataAdr,
  input  wordT writeData,
  input  wordT expAdr  [MaxStores],
  input  wordT expData [MaxStores],
  input  int   numStores,
  input  int   numWords,
  output logic done,
  output int   valueErrors,
  output int   otherErrors
);

  int seen;        // stores matched so far
  int sinceReset;
  int drain;

  initial begin
    done        = 1'b0;
    valueErrors = 0;
    otherErrors = 0;
    seen        = 0;
    sinceReset  = 0;
    drain       = 0;
  end

  task automatic reportValue(input string name, input wordT got, input wordT want);
    $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
    valueErrors++;
  endtask

  task automatic checkStore();
    if (seen >= numStores) begin
      $display("unexpected extra store at %0t ns to address %h", $time, dataAdr);
      otherErrors++;
    end else begin
      if (dataAdr !== expAdr[seen]) reportValue("dataAdr", dataAdr, expAdr[seen]);
      if (writeData !== expData[seen]) reportValue("writeData", writeData, expData[seen]);
      seen++;
    end
  endtask

  always @(posedge clk) begin
    if (!done) begin
      if (!arstN) begin
        if (memWrite !== 1'b0) reportValue("memWrite", {31'b0, memWrite}, 32'h0);
      end else begin
        sinceReset++;
        if (sinceReset == 1 && pc !== 32'h0) reportValue("pc", pc, 32'h0);  // first fetch
        if (sinceReset <= 3 && memWrite !== 1'b0) begin
          reportValue("memWrite", {31'b0, memWrite}, 32'h0);
        end else if (memWrite) begin
          checkStore();
        end
        if (seen == numStores) drain++;
        if (drain >= DrainCycles) begin
          done = 1'b1;
        end else if (sinceReset >= 8 * numWords + 100) begin
          $display("timeout after %0d cycles, %0d of %0d expected stores still missing",
                   sinceReset, numStores - seen, numStores);
          otherErrors++;
          done = 1'b1;
        end
      end
    end
  end

endmodule

/* source/rvPipelineCore.sv */
// ================================================
// RV32I subset pipelined core, top level
// ================================================
`timescale 1ns/1ps

module rvPipelineCore import rvPkg::*; #(
  parameter wordT resetPc = 32'h0
) (
  input  logic clk,
  input  logic arstN,
  input  wordT instr,
  input  wordT readData,
  output wordT pc,
  output logic memWrite,
  output wordT dataAdr,
  output wordT writeData
);

  wordT      instrD, immExtD;
  logic      regWriteD, memWriteD, branchD, jumpD, aluSrcD;
  resultSrcT resultSrcD;
  aluCtrlT   aluCtrlD;

  // hazard handshake
  logic    stall, flushD, flushE;
  fwdSelT  forwardA, forwardB;
  regAddrT rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
  logic    regWriteM, regWriteW, loadE, redirectE;

  controlDecoder uDecoder (
    .instrD(instrD), .regWriteD(regWriteD), .resultSrcD(resultSrcD),
    .memWriteD(memWriteD), .branchD(branchD), .jumpD(jumpD),
    .aluSrcD(aluSrcD), .aluCtrlD(aluCtrlD), .immExtD(immExtD)
  );

  pipelineDatapath #(.resetPc(resetPc)) uDatapath (
    .clk(clk), .arstN(arstN),
    .regWriteD(regWriteD), .resultSrcD(resultSrcD), .memWriteD(memWriteD),
    .branchD(branchD), .jumpD(jumpD), .aluSrcD(aluSrcD),
    .aluCtrlD(aluCtrlD), .immExtD(immExtD),
    .stall(stall), .flushD(flushD), .flushE(flushE),
    .forwardA(forwardA), .forwardB(forwardB),
    .instr(instr), .readData(readData), .instrD(instrD), .pc(pc),
    .dataAdr(dataAdr), .writeData(writeData), .memWrite(memWrite),
    .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E),
    .rdE(rdE), .rdM(rdM), .rdW(rdW),
    .regWriteM(regWriteM), .regWriteW(regWriteW),
    .loadE(loadE), .redirectE(redirectE)
  );

  hazardUnit uHazard (
    .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E),
    .rdE(rdE), .rdM(rdM), .rdW(rdW),
    .regWriteM(regWriteM), .regWriteW(regWriteW),
    .loadE(loadE), .redirectE(redirectE),
    .stall(stall), .flushD(flushD), .flushE(flushE),
    .forwardA(forwardA), .forwardB(forwardB)
  );

endmodule

/* source/pipelineDatapath.sv */
// ================================================
// five-stage datapath: PC, pipeline registers for
// data and control, forwarding and result muxes
// ================================================
`timescale 1ns/1ps

module pipelineDatapath import rvPkg::*; #(
  parameter wordT resetPc = 32'h0
) (
  input  logic      clk,
  input  logic      arstN,
  // decode controls
  input  logic      regWriteD,
  input  resultSrcT resultSrcD,
  input  logic      memWriteD,
  input  logic      branchD,
  input  logic      jumpD,
  input  logic      aluSrcD,
  input  aluCtrlT   aluCtrlD,
  input  wordT      immExtD,
  // hazard controls
  input  logic      stall,
  input  logic      flushD,
  input  logic      flushE,
  input  fwdSelT    forwardA,
  input  fwdSelT    forwardB,
  // memories
  input  wordT      instr,
  input  wordT      readData,
  output wordT      instrD,
  output wordT      pc,
  output wordT      dataAdr,
  output wordT      writeData,
  output logic      memWrite,
  // to hazard unit
  output regAddrT   rs1D,
  output regAddrT   rs2D,
  output regAddrT   rs1E,
  output regAddrT   rs2E,
  output regAddrT   rdE,
  output regAddrT   rdM,
  output regAddrT   rdW,
  output logic      regWriteM,
  output logic      regWriteW,
  output logic      loadE,
  output logic      redirectE
);

  wordT pcPlus4F, pcD, pcPlus4D;
  wordT rfRead1, rfRead2, rd1D, rd2D;
  logic regWriteE, memWriteE, branchE, jumpE, aluSrcE, zeroE;
  resultSrcT resultSrcE, resultSrcM, resultSrcW;
  aluCtrlT aluCtrlE;
  wordT rd1E, rd2E, pcE, immExtE, pcPlus4E;
  wordT srcAE, srcBE, writeDataE, aluResultE, pcTargetE;
  logic memWriteM;
  wordT aluResultM, writeDataM, pcPlus4M;
  wordT aluResultW, readDataW, pcPlus4W, resultW;

  // ================================================
  // fetch
  // ================================================
  assign pcPlus4F = pc + 32'd4;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) pc <= resetPc;
    else if (redirectE) pc <= pcTargetE;  // taken beq or jal
    else if (!stall) pc <= pcPlus4F;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrD   <= '0;  // zero word decodes as a bubble
      pcD      <= '0;
      pcPlus4D <= '0;
    end else if (flushD) begin
      instrD   <= '0;
      pcD      <= '0;
      pcPlus4D <= '0;
    end else if (!stall) begin
      instrD   <= instr;
      pcD      <= pc;
      pcPlus4D <= pcPlus4F;
    end
  end

  // ================================================
  // decode
  // ================================================
  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];

  regFile uRegFile (
    .clk(clk), .arstN(arstN), .writeEn(regWriteW),
    .readAddr1(rs1D), .readAddr2(rs2D), .writeAddr(rdW),
    .writeValue(resultW), .readValue1(rfRead1), .readValue2(rfRead2)
  );

  // writeback bypass, the file still returns the old value this cycle
  assign rd1D = (regWriteW && rdW != '0 && rdW == rs1D) ? resultW : rfRead1;
  assign rd2D = (regWriteW && rdW != '0 && rdW == rs2D) ? resultW : rfRead2;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {regWriteE, memWriteE, branchE, jumpE, aluSrcE} <= '0;
      resultSrcE <= ResAlu;
      aluCtrlE   <= AluAdd;
      {rd1E, rd2E, pcE, immExtE, pcPlus4E} <= '0;
      {rs1E, rs2E, rdE} <= '0;
    end else if (flushE) begin
      {regWriteE, memWriteE, branchE, jumpE, aluSrcE} <= '0;
      resultSrcE <= ResAlu;
      aluCtrlE   <= AluAdd;
      {rd1E, rd2E, pcE, immExtE, pcPlus4E} <= '0;
      {rs1E, rs2E, rdE} <= '0;
    end else begin
      {regWriteE, memWriteE, branchE, jumpE, aluSrcE} <=
        {regWriteD, memWriteD, branchD, jumpD, aluSrcD};
      resultSrcE <= resultSrcD;
      aluCtrlE   <= aluCtrlD;
      {rd1E, rd2E, pcE, immExtE, pcPlus4E} <= {rd1D, rd2D, pcD, immExtD, pcPlus4D};
      {rs1E, rs2E, rdE} <= {rs1D, rs2D, instrD[11:7]};
    end
  end

  // ================================================
  // execute
  // ================================================
  always_comb begin
    case (forwardA)
      FwdMem:  srcAE = aluResultM;
      FwdWb:   srcAE = resultW;
      default: srcAE = rd1E;
    endcase
    case (forwardB)
      FwdMem:  writeDataE = aluResultM;
      FwdWb:   writeDataE = resultW;
      default: writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? immExtE : writeDataE;

  alu uAlu (
    .srcA(srcAE), .srcB(srcBE), .aluCtrl(aluCtrlE),
    .result(aluResultE), .zero(zeroE)
  );

  assign pcTargetE = pcE + immExtE;
  assign redirectE = (zeroE & branchE) | jumpE;
  assign loadE     = (resultSrcE == ResMem);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {regWriteM, memWriteM} <= '0;
      resultSrcM <= ResAlu;
      {aluResultM, writeDataM, pcPlus4M} <= '0;
      rdM <= '0;
    end else begin
      {regWriteM, memWriteM} <= {regWriteE, memWriteE};
      resultSrcM <= resultSrcE;
      {aluResultM, writeDataM, pcPlus4M} <= {aluResultE, writeDataE, pcPlus4E};
      rdM <= rdE;
    end
  end

  // ================================================
  // memory and writeback
  // ================================================
  assign dataAdr   = aluResultM;
  assign writeData = writeDataM;
  assign memWrite  = memWriteM;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteW  <= 1'b0;
      resultSrcW <= ResAlu;
      {aluResultW, readDataW, pcPlus4W} <= '0;
      rdW <= '0;
    end else begin
      regWriteW  <= regWriteM;
      resultSrcW <= resultSrcM;
      {aluResultW, readDataW, pcPlus4W} <= {aluResultM, readData, pcPlus4M};
      rdW <= rdM;
    end
  end

  always_comb begin
    case (resultSrcW)
      ResMem:     resultW = readDataW;
      ResPcPlus4: resultW = pcPlus4W;
      default:    resultW = aluResultW;
    endcase
  end

endmodule

/* source/hazardUnit.sv */
// ================================================
// forwarding selects, load-use stall and flushes
// ================================================
`timescale 1ns/1ps

module hazardUnit import rvPkg::*; (
  input  regAddrT rs1D,
  input  regAddrT rs2D,
  input  regAddrT rs1E,
  input  regAddrT rs2E,
  input  regAddrT rdE,
  input  regAddrT rdM,
  input  regAddrT rdW,
  input  logic    regWriteM,
  input  logic    regWriteW,
  input  logic    loadE,
  input  logic    redirectE,
  output logic    stall,
  output logic    flushD,
  output logic    flushE,
  output fwdSelT  forwardA,
  output fwdSelT  forwardB
);

  // memory stage wins over writeback, x0 never forwarded
  function automatic fwdSelT fwdFor(input regAddrT rsE);
    if (rsE != '0 && regWriteM && rsE == rdM) return FwdMem;
    if (rsE != '0 && regWriteW && rsE == rdW) return FwdWb;
    return FwdNone;
  endfunction

  assign forwardA = fwdFor(rs1E);
  assign forwardB = fwdFor(rs2E);

  assign stall  = loadE && (rdE == rs1D || rdE == rs2D);  // load result not ready yet
  assign flushD = redirectE;
  assign flushE = stall | redirectE;

endmodule

/* source/controlDecoder.sv */
// ================================================
// decode stage control: main decode, ALU decode
// and sign-extended immediate
// ================================================
`timescale 1ns/1ps

module controlDecoder import rvPkg::*; (
  input  wordT      instrD,
  output logic      regWriteD,
  output resultSrcT resultSrcD,
  output logic      memWriteD,
  output logic      branchD,
  output logic      jumpD,
  output logic      aluSrcD,
  output aluCtrlT   aluCtrlD,
  output wordT      immExtD
);

  logic [6:0] op;
  logic [2:0] funct3;
  logic       rTypeSub;     // sub needs R-type and funct7 bit 5
  aluCtrlT    functAluCtrl; // operation picked by funct3
  immSrcT     immSrcD;

  assign op       = instrD[6:0];
  assign funct3   = instrD[14:12];
  assign rTypeSub = instrD[30] & op[5];

  // ================================================
  // ALU decode for R-type and I-type
  // ================================================
  always_comb begin
    case (funct3)
      3'b000:  functAluCtrl = rTypeSub ? AluSub : AluAdd;
      3'b010:  functAluCtrl = AluSlt;
      3'b110:  functAluCtrl = AluOr;
      3'b111:  functAluCtrl = AluAnd;
      default: functAluCtrl = AluAdd;  // outside the subset
    endcase
  end

  // main decode, unknown opcodes become a no-op
  always_comb begin
    regWriteD  = 1'b0;
    resultSrcD = ResAlu;
    memWriteD  = 1'b0;
    branchD    = 1'b0;
    jumpD      = 1'b0;
    aluSrcD    = 1'b0;
    aluCtrlD   = AluAdd;
    immSrcD    = ImmI;
    case (op)
      OpLoad: begin
        regWriteD  = 1'b1;
        resultSrcD = ResMem;
        aluSrcD    = 1'b1;
      end
      OpStore: begin
        memWriteD = 1'b1;
        aluSrcD   = 1'b1;
        immSrcD   = ImmS;
      end
      OpRType: begin
        regWriteD = 1'b1;
        aluCtrlD  = functAluCtrl;
      end
      OpIType: begin
        regWriteD = 1'b1;
        aluSrcD   = 1'b1;
        aluCtrlD  = functAluCtrl;
      end
      OpBranch: begin
        branchD  = 1'b1;
        aluCtrlD = AluSub;  // beq compares via zero flag
        immSrcD  = ImmB;
      end
      OpJal: begin
        regWriteD  = 1'b1;
        resultSrcD = ResPcPlus4;
        jumpD      = 1'b1;
        immSrcD    = ImmJ;
      end
      default: ;
    endcase
  end

  // immediate extension
  always_comb begin
    case (immSrcD)
      ImmS:    immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
      ImmB:    immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
      ImmJ:    immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
      default: immExtD = {{20{instrD[31]}}, instrD[31:20]};
    endcase
  end

endmodule

/* source/regFile.sv */
// ================================================
// 32 x 32 register file, x0 reads as zero
// ================================================
`timescale 1ns/1ps

module regFile import rvPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    writeEn,
  input  regAddrT readAddr1,
  input  regAddrT readAddr2,
  input  regAddrT writeAddr,
  input  wordT    writeValue,
  output wordT    readValue1,
  output wordT    readValue2
);

  wordT regs [32];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (writeEn && writeAddr != '0) begin
      regs[writeAddr] <= writeValue;
    end
  end

  assign readValue1 = (readAddr1 != '0) ? regs[readAddr1] : '0;
  assign readValue2 = (readAddr2 != '0) ? regs[readAddr2] : '0;

endmodule

/* source/alu.sv */
// ================================================
// ALU for add, sub, and, or and slt
// ================================================
`timescale 1ns/1ps

module alu import rvPkg::*; (
  input  wordT    srcA,
  input  wordT    srcB,
  input  aluCtrlT aluCtrl,
  output wordT    result,
  output logic    zero
);

  wordT condInvB;
  wordT sum;
  logic overflow;

  // one adder serves add, sub and slt
  assign condInvB = aluCtrl[0] ? ~srcB : srcB;
  assign sum      = srcA + condInvB + {31'b0, aluCtrl[0]};

  assign overflow = ~(aluCtrl[0] ^ srcA[31] ^ srcB[31]) & (srcA[31] ^ sum[31]);

  always_comb begin
    case (aluCtrl)
      AluAdd:  result = sum;
      AluSub:  result = sum;
      AluAnd:  result = srcA & srcB;
      AluOr:   result = srcA | srcB;
      AluSlt:  result = {31'b0, sum[31] ^ overflow};  // sign corrected for overflow
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

/* source/rvPkg.sv */
// ================================================
// shared widths, control encodings and opcodes
// for the RV32I subset pipeline core
// ================================================
package rvPkg;

  // ================================================
  // vector types
  // ================================================
  typedef logic [31:0] wordT;       // data, address, instruction
  typedef logic [4:0]  regAddrT;    // register index
  typedef logic [2:0]  aluCtrlT;
  typedef logic [1:0]  immSrcT;
  typedef logic [1:0]  resultSrcT;
  typedef logic [1:0]  fwdSelT;

  // alu operations, bit 0 set means the adder subtracts
  localparam aluCtrlT AluAdd = 3'b000;
  localparam aluCtrlT AluSub = 3'b001;
  localparam aluCtrlT AluAnd = 3'b010;
  localparam aluCtrlT AluOr  = 3'b011;
  localparam aluCtrlT AluSlt = 3'b101;

  // immediate formats
  localparam immSrcT ImmI = 2'b00;
  localparam immSrcT ImmS = 2'b01;
  localparam immSrcT ImmB = 2'b10;
  localparam immSrcT ImmJ = 2'b11;

  // writeback source
  localparam resultSrcT ResAlu     = 2'b00;
  localparam resultSrcT ResMem     = 2'b01;
  localparam resultSrcT ResPcPlus4 = 2'b10;

  // forward selects for the execute operands
  localparam fwdSelT FwdNone = 2'b00;
  localparam fwdSelT FwdWb   = 2'b01;
  localparam fwdSelT FwdMem  = 2'b10;

  // opcodes of the supported subset
  localparam logic [6:0] OpLoad   = 7'b0000011;
  localparam logic [6:0] OpStore  = 7'b0100011;
  localparam logic [6:0] OpRType  = 7'b0110011;
  localparam logic [6:0] OpIType  = 7'b0010011;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpJal    = 7'b1101111;

endpackage
